/* source/exe_pkg.sv */
`default_nettype none

package exe_pkg;

    localparam int xlen      = 32;
    localparam int csr_num_w = 14;
    localparam int div_steps = 32;

    typedef enum logic [4:0] {
        op_add, op_sub, op_slt, op_sltu,
        op_and, op_or, op_nor, op_xor,
        op_sll, op_srl, op_sra, op_lui,
        op_mul, op_mulh, op_mulhu,
        op_div, op_mod, op_divu, op_modu
    } alu_op_t;

    typedef enum logic [2:0] {ld_none, ld_b, ld_h, ld_w, ld_bu, ld_hu} load_op_t;

    typedef enum logic [1:0] {st_none, st_b, st_h, st_w} store_op_t;

    typedef struct packed {
        logic adef;
        logic brk;
        logic ine;
        logic intr;
        logic sys;
        logic ale;
    } exc_flags_t;

    typedef struct packed {
        logic                 we;
        logic                 re;
        logic [csr_num_w-1:0] wnum;
        logic [xlen-1:0]      wmask;
        logic [xlen-1:0]      wdata;
        logic [xlen-1:0]      rdata;
    } csr_op_t;

    typedef struct packed {
        csr_op_t         csr;
        logic            ertn;
        exc_flags_t      exc;
        alu_op_t         alu_op;
        load_op_t        load_op;
        store_op_t       store_op;
        logic            src1_is_pc;
        logic            src2_is_imm;
        logic            gr_we;
        logic [4:0]      dest;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] rj_value;
        logic [xlen-1:0] rkd_value;
        logic [xlen-1:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        csr_op_t         csr;
        logic            ertn;
        exc_flags_t      exc;
        logic            res_from_mul;
        load_op_t        load_op;
        logic            gr_we;
        logic [4:0]      dest;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] pc;
    } es_to_ms_t;

    typedef struct packed {
        logic            en;
        logic [3:0]      wen;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
    } sram_req_t;

    typedef struct packed {
        logic            we;
        logic            blk;   // value not ready yet in EX
        logic [4:0]      dest;
        logic [xlen-1:0] value;
    } fwd_blk_t;

    typedef struct packed {
        logic                 we;
        logic                 ertn;
        logic [csr_num_w-1:0] wnum;
    } csr_blk_t;

    typedef struct packed {
        logic              hi_sel;
        logic [2*xlen-1:0] prod;
    } mul_res_t;

endpackage

`default_nettype wire

/* source/div_unit.sv */
`default_nettype none

module div_unit (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  logic                     is_signed,
    input  logic                     abort,
    input  logic                     advance,
    input  logic [exe_pkg::xlen-1:0] dividend,
    input  logic [exe_pkg::xlen-1:0] divisor,
    output logic                     finish,
    output logic [exe_pkg::xlen-1:0] quotient,
    output logic [exe_pkg::xlen-1:0] remainder
);
    import exe_pkg::*;

    typedef enum logic [1:0] {div_idle, div_busy, div_done} div_state_t;

    div_state_t                     state;
    logic [$clog2(div_steps)-1:0]   step_cnt;
    logic                           last_step;
    logic [xlen-1:0]                quo;   // dividend shifts out, quotient shifts in
    logic [xlen-1:0]                rem;
    logic [xlen-1:0]                dvsr;
    logic                           q_neg;
    logic                           r_neg;
    logic                           by_zero;
    logic                           dvd_neg;
    logic                           dvs_neg;
    logic [xlen:0]                  partial;
    logic [xlen:0]                  diff;

    assign dvd_neg   = is_signed & dividend[xlen-1];
    assign dvs_neg   = is_signed & divisor[xlen-1];
    assign last_step = (step_cnt == $bits(step_cnt)'(div_steps - 1));

    // one restoring step
    assign partial = {rem, quo[xlen-1]};
    assign diff    = partial - {1'b0, dvsr};

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= div_idle;
            step_cnt <= '0;
        end else if (abort) begin
            state <= div_idle;
        end else begin
            case (state)
                div_idle: begin
                    if (start) begin
                        state    <= div_busy;
                        step_cnt <= '0;
                    end
                end
                div_busy: begin
                    step_cnt <= step_cnt + 1'b1;
                    if (last_step)
                        state <= div_done;
                end
                div_done: begin
                    if (advance)
                        state <= div_idle;
                end
                default: state <= div_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == div_idle && start) begin
            quo     <= dvd_neg ? -dividend : dividend;  // magnitudes
            dvsr    <= dvs_neg ? -divisor : divisor;
            rem     <= '0;
            q_neg   <= dvd_neg ^ dvs_neg;
            r_neg   <= dvd_neg;
            by_zero <= (divisor == '0);
        end else if (state == div_busy) begin
            rem <= diff[xlen] ? partial[xlen-1:0] : diff[xlen-1:0];
            quo <= {quo[xlen-2:0], ~diff[xlen]};
        end
    end

    assign finish   = (state == div_done);
    assign quotient = by_zero ? '1 : (q_neg ? -quo : quo);
    // on divide by zero rem ends up as the dividend magnitude already
    assign remainder = r_neg ? -rem : rem;

    start_only_when_idle: assert property (@(posedge clk) disable iff (reset)
        start |-> state == div_idle);

endmodule

`default_nettype wire

/* source/alu.sv */
`default_nettype none

module alu (
    input  logic                     clk,
    input  logic                     reset,
    input  exe_pkg::alu_op_t         alu_op,
    input  logic [exe_pkg::xlen-1:0] src1,
    input  logic [exe_pkg::xlen-1:0] src2,
    input  logic                     op_valid,
    input  logic                     advance,
    input  logic                     flush,
    output logic [exe_pkg::xlen-1:0] alu_result,
    output logic                     div_busy_stall,
    output exe_pkg::mul_res_t        mul_res_bus
);
    import exe_pkg::*;

    logic                is_sub;
    logic [xlen-1:0]     add_b;
    logic [xlen-1:0]     add_res;
    logic                add_cout;
    logic                slt_res;
    logic                sltu_res;
    logic [xlen-1:0]     sll_res;
    logic [xlen-1:0]     srl_res;
    logic [xlen-1:0]     sra_res;
    logic                mul_signed;
    logic [xlen:0]       mul_a;
    logic [xlen:0]       mul_b;
    logic [2*xlen-1:0]   mul_prod;
    logic                is_div_op;
    logic                div_signed;
    logic                div_start;
    logic                div_pending;
    logic                div_finish;
    logic [xlen-1:0]     div_q;
    logic [xlen-1:0]     div_r;

    // shared adder, compares run through subtract
    assign is_sub = (alu_op == op_sub) | (alu_op == op_slt) | (alu_op == op_sltu);
    assign add_b  = is_sub ? ~src2 : src2;
    assign {add_cout, add_res} = {1'b0, src1} + {1'b0, add_b} + {{xlen{1'b0}}, is_sub};

    assign slt_res  = (src1[xlen-1] & ~src2[xlen-1])
                    | (~(src1[xlen-1] ^ src2[xlen-1]) & add_res[xlen-1]);
    assign sltu_res = ~add_cout;

    assign sll_res = src1 << src2[4:0];
    assign srl_res = src1 >> src2[4:0];
    assign sra_res = $signed(src1) >>> src2[4:0];

    // 33-bit extension covers both signed and unsigned high word
    assign mul_signed = (alu_op == op_mulh);
    assign mul_a      = {mul_signed & src1[xlen-1], src1};
    assign mul_b      = {mul_signed & src2[xlen-1], src2};
    assign mul_prod   = $signed(mul_a) * $signed(mul_b);

    assign mul_res_bus.hi_sel = (alu_op == op_mulh) | (alu_op == op_mulhu);
    assign mul_res_bus.prod   = mul_prod;

    assign is_div_op  = alu_op inside {op_div, op_mod, op_divu, op_modu};
    assign div_signed = alu_op inside {op_div, op_mod};
    assign div_start  = op_valid & is_div_op & ~div_pending;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            div_pending <= 1'b0;
        end else if (advance) begin
            div_pending <= 1'b0;
        end else if (div_start) begin
            div_pending <= 1'b1;
        end
    end

    assign div_busy_stall = op_valid & is_div_op & ~div_finish;

    div_unit div_unit_inst (
        .clk       (clk),
        .reset     (reset),
        .start     (div_start),
        .is_signed (div_signed),
        .abort     (flush),
        .advance   (advance),
        .dividend  (src1),
        .divisor   (src2),
        .finish    (div_finish),
        .quotient  (div_q),
        .remainder (div_r)
    );

    always_comb begin
        case (alu_op)
            op_add, op_sub: alu_result = add_res;
            op_slt:         alu_result = {{(xlen-1){1'b0}}, slt_res};
            op_sltu:        alu_result = {{(xlen-1){1'b0}}, sltu_res};
            op_and:         alu_result = src1 & src2;
            op_or:          alu_result = src1 | src2;
            op_nor:         alu_result = ~(src1 | src2);
            op_xor:         alu_result = src1 ^ src2;
            op_sll:         alu_result = sll_res;
            op_srl:         alu_result = srl_res;
            op_sra:         alu_result = sra_res;
            op_lui:         alu_result = src2;   // imm comes in pre-shifted
            op_mul:         alu_result = mul_prod[xlen-1:0];
            op_mulh,
            op_mulhu:       alu_result = mul_prod[2*xlen-1:xlen];
            op_div, op_divu: alu_result = div_q;
            op_mod, op_modu: alu_result = div_r;
            default:        alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/exe_stage.sv */
`default_nettype none

module exe_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ds_to_es_valid,
    input  exe_pkg::ds_to_es_t   ds_to_es_bus,
    input  logic                 ms_allowin,
    input  logic                 wb_exc,
    input  logic                 wb_ertn,
    input  logic                 ms_to_es_st_cancel,
    output logic                 es_allowin,
    output logic                 es_to_ms_valid,
    output exe_pkg::es_to_ms_t   es_to_ms_bus,
    output exe_pkg::sram_req_t   sram_req,
    output exe_pkg::fwd_blk_t    es_fwd_blk_bus,
    output exe_pkg::csr_blk_t    es_csr_blk_bus,
    output exe_pkg::mul_res_t    es_mul_res_bus
);
    import exe_pkg::*;

    logic            es_valid;
    logic            es_ready_go;
    ds_to_es_t       es_r;
    logic            flush;
    logic            advance;
    logic [xlen-1:0] alu_src1;
    logic [xlen-1:0] alu_src2;
    logic [xlen-1:0] alu_result;
    logic            div_busy_stall;
    logic [1:0]      addr_lo;
    logic            is_load;
    logic            is_store;
    logic            is_half;
    logic            is_word;
    logic            ale;
    logic            res_from_mul;
    logic            store_cancel;
    exc_flags_t      exc;

    assign flush          = wb_exc | wb_ertn;
    assign es_ready_go    = ~div_busy_stall;
    assign es_allowin     = ~es_valid | (es_ready_go & ms_allowin);
    assign es_to_ms_valid = es_valid & es_ready_go;
    assign advance        = es_to_ms_valid & ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (flush) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_to_es_valid && es_allowin)
            es_r <= ds_to_es_bus;
    end

    assign alu_src1 = es_r.src1_is_pc ? es_r.pc : es_r.rj_value;
    assign alu_src2 = es_r.src2_is_imm ? es_r.imm : es_r.rkd_value;

    alu alu_inst (
        .clk            (clk),
        .reset          (reset),
        .alu_op         (es_r.alu_op),
        .src1           (alu_src1),
        .src2           (alu_src2),
        .op_valid       (es_valid),
        .advance        (advance),
        .flush          (flush),
        .alu_result     (alu_result),
        .div_busy_stall (div_busy_stall),
        .mul_res_bus    (es_mul_res_bus)
    );

    assign addr_lo      = alu_result[1:0];
    assign is_load      = (es_r.load_op != ld_none);
    assign is_store     = (es_r.store_op != st_none);
    assign is_half      = (es_r.load_op inside {ld_h, ld_hu}) | (es_r.store_op == st_h);
    assign is_word      = (es_r.load_op == ld_w) | (es_r.store_op == st_w);
    assign ale          = (is_half & addr_lo[0]) | (is_word & (|addr_lo));
    assign res_from_mul = es_r.alu_op inside {op_mul, op_mulh, op_mulhu};

    always_comb begin
        exc     = es_r.exc;
        exc.ale = es_r.exc.ale | ale;
    end

    assign store_cancel = flush | ms_to_es_st_cancel | (|exc);

    always_comb begin
        sram_req.en   = (is_load | is_store) & es_valid & ~store_cancel;
        sram_req.addr = {alu_result[xlen-1:2], 2'b00};
        case (es_r.store_op)
            st_b: begin
                sram_req.wen   = 4'b0001 << addr_lo;
                sram_req.wdata = {4{es_r.rkd_value[7:0]}};
            end
            st_h: begin
                sram_req.wen   = 4'b0011 << {addr_lo[1], 1'b0};
                sram_req.wdata = {2{es_r.rkd_value[15:0]}};
            end
            st_w: begin
                sram_req.wen   = 4'b1111;
                sram_req.wdata = es_r.rkd_value;
            end
            default: begin  // loads and non-memory ops
                sram_req.wen   = 4'b0000;
                sram_req.wdata = es_r.rkd_value;
            end
        endcase
    end

    assign es_to_ms_bus.csr          = es_r.csr;
    assign es_to_ms_bus.ertn         = es_r.ertn;
    assign es_to_ms_bus.exc          = exc;
    assign es_to_ms_bus.res_from_mul = res_from_mul;
    assign es_to_ms_bus.load_op      = es_r.load_op;
    assign es_to_ms_bus.gr_we        = es_r.gr_we;
    assign es_to_ms_bus.dest         = es_r.dest;
    assign es_to_ms_bus.alu_result   = alu_result;
    assign es_to_ms_bus.pc           = es_r.pc;

    assign es_fwd_blk_bus.we    = es_r.gr_we & es_valid;
    assign es_fwd_blk_bus.blk   = (is_load | res_from_mul) & es_valid;  // finishes in MEM
    assign es_fwd_blk_bus.dest  = es_r.dest;
    assign es_fwd_blk_bus.value = alu_result;

    assign es_csr_blk_bus.we   = es_r.csr.we & es_valid;
    assign es_csr_blk_bus.ertn = es_r.ertn & es_valid;
    assign es_csr_blk_bus.wnum = es_r.csr.wnum;

    out_valid_needs_item: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid |-> es_valid);

    no_sram_during_flush: assert property (@(posedge clk) disable iff (reset)
        (wb_exc || wb_ertn) |-> !sram_req.en);

    // a stalled item must not change under back-pressure
    hold_under_backpressure: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid && !ms_allowin && !(wb_exc || wb_ertn)
        |=> es_to_ms_valid && $stable(es_to_ms_bus));

endmodule

`default_nettype wire

/* source/exe_top.sv */
`default_nettype none

module exe_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 ds_to_es_valid,
    input  exe_pkg::ds_to_es_t   ds_to_es_bus,
    input  logic                 ms_allowin,
    input  logic                 wb_exc,
    input  logic                 wb_ertn,
    input  logic                 ms_to_es_st_cancel,
    output logic                 es_allowin,
    output logic                 es_to_ms_valid,
    output exe_pkg::es_to_ms_t   es_to_ms_bus,
    output exe_pkg::sram_req_t   sram_req,
    output exe_pkg::fwd_blk_t    es_fwd_blk_bus,
    output exe_pkg::csr_blk_t    es_csr_blk_bus,
    output exe_pkg::mul_res_t    es_mul_res_bus
);

    // execute stage plus ALU, divider below it
    exe_stage exe_stage_inst (
        .clk                (clk),
        .reset              (reset),
        .ds_to_es_valid     (ds_to_es_valid),
        .ds_to_es_bus       (ds_to_es_bus),
        .ms_allowin         (ms_allowin),
        .wb_exc             (wb_exc),
        .wb_ertn            (wb_ertn),
        .ms_to_es_st_cancel (ms_to_es_st_cancel),
        .es_allowin         (es_allowin),
        .es_to_ms_valid     (es_to_ms_valid),
        .es_to_ms_bus       (es_to_ms_bus),
        .sram_req           (sram_req),
        .es_fwd_blk_bus     (es_fwd_blk_bus),
        .es_csr_blk_bus     (es_csr_blk_bus),
        .es_mul_res_bus     (es_mul_res_bus)
    );

endmodule

`default_nettype wire

/* include/exe_tb_vectors.svh */
alu_entry(op_add,   2'b00, 32'h00000005, 32'h00000007, 32'h0000000c);
alu_entry(op_add,   2'b01, 32'h00000010, 32'hfffffff8, 32'h00000008);
alu_entry(op_add,   2'b11, 32'h1c000040, 32'h00012000, 32'h1c012040);  // pc + imm
alu_entry(op_sub,   2'b00, 32'h00000003, 32'h00000005, 32'hfffffffe);
alu_entry(op_slt,   2'b00, 32'hffffffff, 32'h00000001, 32'h00000001);
alu_entry(op_slt,   2'b00, 32'h00000001, 32'hffffffff, 32'h00000000);
alu_entry(op_slt,   2'b00, 32'h80000000, 32'h7fffffff, 32'h00000001);
alu_entry(op_sltu,  2'b00, 32'hffffffff, 32'h00000001, 32'h00000000);
alu_entry(op_sltu,  2'b00, 32'h00000001, 32'hffffffff, 32'h00000001);
alu_entry(op_and,   2'b00, 32'hf0f0ff00, 32'h0ff0f0f0, 32'h00f0f000);
alu_entry(op_or,    2'b00, 32'hf0f0ff00, 32'h0ff0f0f0, 32'hfff0fff0);
alu_entry(op_nor,   2'b00, 32'hf0f0ff00, 32'h0ff0f0f0, 32'h000f000f);
alu_entry(op_xor,   2'b00, 32'hf0f0ff00, 32'h0ff0f0f0, 32'hff000ff0);
alu_entry(op_sll,   2'b00, 32'h80000001, 32'h00000024, 32'h00000010);  // only low 5 bits shift
alu_entry(op_srl,   2'b00, 32'h80000010, 32'h00000004, 32'h08000001);
alu_entry(op_sra,   2'b00, 32'h80000010, 32'h00000004, 32'hf8000001);
alu_entry(op_sra,   2'b01, 32'h80000000, 32'h0000001f, 32'hffffffff);
alu_entry(op_lui,   2'b01, 32'h00001234, 32'habcde000, 32'habcde000);
alu_entry(op_mul,   2'b00, 32'h00012345, 32'h00010000, 32'h23450000);
alu_entry(op_mul,   2'b00, 32'hfffffffe, 32'h00000003, 32'hfffffffa);
alu_entry(op_mulh,  2'b00, 32'hfffffffe, 32'h00000003, 32'hffffffff);
alu_entry(op_mulhu, 2'b00, 32'hfffffffe, 32'h00000003, 32'h00000002);
alu_entry(op_mulh,  2'b00, 32'h80000000, 32'h80000000, 32'h40000000);
alu_entry(op_mulh,  2'b00, 32'hffffffff, 32'hffffffff, 32'h00000000);
alu_entry(op_mulhu, 2'b00, 32'hffffffff, 32'hffffffff, 32'hfffffffe);
alu_entry(op_div,   2'b00, 32'hffffff9c, 32'h00000007, 32'hfffffff2);
alu_entry(op_mod,   2'b00, 32'hffffff9c, 32'h00000007, 32'hfffffffe);
alu_entry(op_div,   2'b00, 32'h00000064, 32'hfffffff9, 32'hfffffff2);
alu_entry(op_mod,   2'b00, 32'h00000064, 32'hfffffff9, 32'h00000002);
alu_entry(op_div,   2'b00, 32'hffffff9c, 32'hfffffff9, 32'h0000000e);
alu_entry(op_divu,  2'b00, 32'hffffffff, 32'h00000010, 32'h0fffffff);
alu_entry(op_modu,  2'b00, 32'hffffffff, 32'h00000010, 32'h0000000f);
alu_entry(op_div,   2'b00, 32'hfffffff6, 32'h00000000, 32'hffffffff);
alu_entry(op_mod,   2'b00, 32'hfffffff6, 32'h00000000, 32'hfffffff6);
alu_entry(op_divu,  2'b00, 32'h00000007, 32'h00000000, 32'hffffffff);
alu_entry(op_modu,  2'b00, 32'h12345678, 32'h00000000, 32'h12345678);
mem_entry(ld_none, st_b, 32'h00000000, 32'h00000100, 1, 4'b0001, 32'h44444444, 0);
mem_entry(ld_none, st_b, 32'h00000001, 32'h00000101, 1, 4'b0010, 32'h44444444, 0);
mem_entry(ld_none, st_b, 32'h00000002, 32'h00000102, 1, 4'b0100, 32'h44444444, 0);
mem_entry(ld_none, st_b, 32'h00000003, 32'h00000103, 1, 4'b1000, 32'h44444444, 0);
mem_entry(ld_none, st_h, 32'h00000000, 32'h00000100, 1, 4'b0011, 32'h33443344, 0);
mem_entry(ld_none, st_h, 32'h00000002, 32'h00000102, 1, 4'b1100, 32'h33443344, 0);
mem_entry(ld_none, st_w, 32'h00000004, 32'h00000104, 1, 4'b1111, 32'h11223344, 0);
mem_entry(ld_w,  st_none, 32'h00000008, 32'h00000108, 1, 4'b0000, 32'h00000000, 0);
mem_entry(ld_b,  st_none, 32'h00000003, 32'h00000103, 1, 4'b0000, 32'h00000000, 0);
mem_entry(ld_bu, st_none, 32'h00000001, 32'h00000101, 1, 4'b0000, 32'h00000000, 0);
mem_entry(ld_hu, st_none, 32'h00000002, 32'h00000102, 1, 4'b0000, 32'h00000000, 0);
mem_entry(ld_h,  st_none, 32'h00000000, 32'h00000100, 1, 4'b0000, 32'h00000000, 0);
mem_entry(ld_none, st_h, 32'h00000001, 32'h00000101, 0, 4'b0000, 32'h00000000, 1);
mem_entry(ld_none, st_w, 32'h00000002, 32'h00000102, 0, 4'b0000, 32'h00000000, 1);
mem_entry(ld_h,  st_none, 32'h00000003, 32'h00000103, 0, 4'b0000, 32'h00000000, 1);
mem_entry(ld_hu, st_none, 32'h00000001, 32'h00000101, 0, 4'b0000, 32'h00000000, 1);
mem_entry(ld_w,  st_none, 32'h00000001, 32'h00000101, 0, 4'b0000, 32'h00000000, 1);
mem_entry(ld_w,  st_none, 32'h00000002, 32'h00000102, 0, 4'b0000, 32'h00000000, 1);

/* test/exe_tb.sv */
`default_nettype none

module exe_tb;
    import exe_pkg::*;

    typedef struct {
        alu_op_t     op;
        load_op_t    ld;
        store_op_t   st;
        logic        pc_sel;
        logic        imm_sel;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] res;
        logic        en;
        logic [3:0]  wen;
        logic [31:0] wdata;
        logic        ale;
    } vec_t;

    logic      clk;
    logic      reset;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es_bus;
    logic      ms_allowin;
    logic      wb_exc;
    logic      wb_ertn;
    logic      ms_to_es_st_cancel;
    logic      es_allowin;
    logic      es_to_ms_valid;
    es_to_ms_t es_to_ms_bus;
    sram_req_t sram_req;
    fwd_blk_t  es_fwd_blk_bus;
    csr_blk_t  es_csr_blk_bus;
    mul_res_t  es_mul_res_bus;

    vec_t   vecs[$];
    int     expect_q[$];   // table indices in issue order
    int     num_table;
    int     st_idx;
    int     div_a_idx;
    int     div_b_idx;
    integer seed;
    int     allow_mode;    // 0 random, 1 held low, 2 held high
    int     cycles;
    int     cycle_limit;
    int     num_checks;
    int     value_errors;
    int     other_errors;

    exe_top exe_top_inst (
        .clk                (clk),
        .reset              (reset),
        .ds_to_es_valid     (ds_to_es_valid),
        .ds_to_es_bus       (ds_to_es_bus),
        .ms_allowin         (ms_allowin),
        .wb_exc             (wb_exc),
        .wb_ertn            (wb_ertn),
        .ms_to_es_st_cancel (ms_to_es_st_cancel),
        .es_allowin         (es_allowin),
        .es_to_ms_valid     (es_to_ms_valid),
        .es_to_ms_bus       (es_to_ms_bus),
        .sram_req           (sram_req),
        .es_fwd_blk_bus     (es_fwd_blk_bus),
        .es_csr_blk_bus     (es_csr_blk_bus),
        .es_mul_res_bus     (es_mul_res_bus)
    );

    task automatic alu_entry(input alu_op_t op, input logic [1:0] sel,
                             input logic [31:0] a, input logic [31:0] b,
                             input logic [31:0] res);
        vec_t v;
        v = '{op, ld_none, st_none, sel[1], sel[0], a, b, res, 1'b0, 4'h0, 32'h0, 1'b0};
        vecs.push_back(v);
    endtask

    // address is base 0x100 plus imm
    task automatic mem_entry(input load_op_t ld, input store_op_t st, input logic [31:0] imm,
                             input logic [31:0] res, input logic en, input logic [3:0] wen,
                             input logic [31:0] wdata, input logic ale);
        vec_t v;
        v = '{op_add, ld, st, 1'b0, 1'b1, 32'h00000100, imm, res, en, wen, wdata, ale};
        vecs.push_back(v);
    endtask

    task automatic load_table;
        `include "exe_tb_vectors.svh"
    endtask

    // unused operand fields carry decoys so a wrong select shows up
    function automatic ds_to_es_t bus_of(input vec_t v, input int idx);
        ds_to_es_t b;
        b             = '0;
        b.alu_op      = v.op;
        b.load_op     = v.ld;
        b.store_op    = v.st;
        b.src1_is_pc  = v.pc_sel;
        b.src2_is_imm = v.imm_sel;
        b.gr_we       = (v.st == st_none);
        b.dest        = idx[4:0];
        b.csr.we      = idx[0];
        b.csr.wnum    = idx[13:0];
        b.ertn        = idx[1];
        b.pc          = v.pc_sel ? v.src1 : {20'h1c000, idx[9:0], 2'b00};
        b.rj_value    = v.pc_sel ? 32'h0000dead : v.src1;
        b.imm         = v.imm_sel ? v.src2 : 32'h0badf00d;
        b.rkd_value   = v.imm_sel ? 32'h11223344 : v.src2;  // store data
        return b;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        num_checks++;
        if (got !== exp) begin
            value_errors++;
            $display("error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic check_output;
        int   idx;
        vec_t v;
        logic is_mul;
        if (expect_q.size() == 0) begin
            other_errors++;
            $display("an item left the stage at %0t while none was pending", $time);
            return;
        end
        idx    = expect_q.pop_front();
        v      = vecs[idx];
        is_mul = v.op inside {op_mul, op_mulh, op_mulhu};
        check_value("dest", es_to_ms_bus.dest, idx[4:0]);
        check_value("pc", es_to_ms_bus.pc, v.pc_sel ? v.src1 : {20'h1c000, idx[9:0], 2'b00});
        check_value("gr_we", es_to_ms_bus.gr_we, v.st == st_none);
        check_value("load_op", es_to_ms_bus.load_op, v.ld);
        check_value("ertn", es_to_ms_bus.ertn, idx[1]);
        check_value("csr wnum", es_to_ms_bus.csr.wnum, idx[13:0]);
        check_value("alu_result", es_to_ms_bus.alu_result, v.res);
        check_value("exc.ale", es_to_ms_bus.exc.ale, v.ale);
        check_value("res_from_mul", es_to_ms_bus.res_from_mul, is_mul);
        check_value("sram en", sram_req.en, v.en);
        check_value("fwd blk", es_fwd_blk_bus.blk, is_mul || v.ld != ld_none);
        check_value("fwd we", es_fwd_blk_bus.we, v.st == st_none);
        check_value("fwd dest", es_fwd_blk_bus.dest, idx[4:0]);
        check_value("fwd value", es_fwd_blk_bus.value, v.res);
        check_value("csr blk we", es_csr_blk_bus.we, idx[0]);
        check_value("csr blk ertn", es_csr_blk_bus.ertn, idx[1]);
        check_value("csr blk wnum", es_csr_blk_bus.wnum, idx[13:0]);
        if (v.en) begin
            check_value("sram addr", sram_req.addr, {v.res[31:2], 2'b00});
            check_value("sram wen", sram_req.wen, v.wen);
            if (v.st != st_none)
                check_value("sram wdata", sram_req.wdata, v.wdata);
        end
        if (is_mul) begin
            check_value("mul hi_sel", es_mul_res_bus.hi_sel, v.op != op_mul);
            if (v.op == op_mul)
                check_value("mul prod low", es_mul_res_bus.prod[31:0], v.res);
            else
                check_value("mul prod high", es_mul_res_bus.prod[63:32], v.res);
        end
    endtask

    // called at a drive point, returns at the drive point after the accepting edge
    task automatic offer_item(input int idx, input logic track);
        ds_to_es_valid = 1'b1;
        ds_to_es_bus   = bus_of(vecs[idx], idx);
        @(negedge clk);
        while (!es_allowin)
            @(negedge clk);
        if (track)
            expect_q.push_back(idx);
        @(posedge clk);
        #1;
        ds_to_es_valid = 1'b0;
    endtask

    task automatic wait_drain;
        while (expect_q.size() != 0)
            @(posedge clk);
        @(posedge clk);
        #1;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        #1;
        case (allow_mode)
            1:       ms_allowin = 1'b0;
            2:       ms_allowin = 1'b1;
            default: ms_allowin = (($random(seed) % 4) != 0);
        endcase
    end

    always @(negedge clk) begin
        if (!reset && es_to_ms_valid && ms_allowin)
            check_output();
    end

    always @(posedge clk)
        cycles++;

    initial begin
        @(posedge clk);
        wait (cycles > cycle_limit);
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        ds_to_es_valid     = 1'b0;
        ds_to_es_bus       = '0;
        ms_allowin         = 1'b0;
        wb_exc             = 1'b0;
        wb_ertn            = 1'b0;
        ms_to_es_st_cancel = 1'b0;
        reset              = 1'b1;
        seed               = 32'h5f7f;
        allow_mode         = 0;
        cycles             = 0;
        num_checks         = 0;
        value_errors       = 0;
        other_errors       = 0;
        load_table();
        num_table = vecs.size();
        st_idx    = num_table;
        mem_entry(ld_none, st_w, 32'h0, 32'h00000100, 1, 4'b1111, 32'h11223344, 0);
        div_a_idx = num_table + 1;
        alu_entry(op_divu, 2'b00, 32'h00001000, 32'h00000003, 32'h00000555);
        div_b_idx = num_table + 2;
        alu_entry(op_mod, 2'b00, 32'hffffff85, 32'h0000000a, 32'hfffffffd);
        cycle_limit = vecs.size() * 40 + 200;

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_value("allowin after reset", es_allowin, 1);
        check_value("out valid after reset", es_to_ms_valid, 0);
        check_value("sram en after reset", sram_req.en, 0);
        check_value("fwd we after reset", es_fwd_blk_bus.we, 0);
        check_value("csr we after reset", es_csr_blk_bus.we, 0);
        @(posedge clk);
        #1;

        for (int i = 0; i < num_table; i++)
            offer_item(i, 1'b1);
        wait_drain();

        // store parked in EX by back-pressure, then cancelled and flushed
        @(negedge clk);
        allow_mode = 1;
        @(posedge clk);
        #1;
        offer_item(st_idx, 1'b0);
        @(negedge clk);
        check_value("store en while parked", sram_req.en, 1);
        @(posedge clk);
        #1;
        ms_to_es_st_cancel = 1'b1;
        @(negedge clk);
        check_value("store en on mem cancel", sram_req.en, 0);
        @(posedge clk);
        #1;
        ms_to_es_st_cancel = 1'b0;
        wb_exc             = 1'b1;
        @(negedge clk);
        check_value("store en on wb_exc", sram_req.en, 0);
        @(posedge clk);
        #1;
        wb_exc = 1'b0;
        @(negedge clk);
        check_value("out valid after flush", es_to_ms_valid, 0);

        // divide dropped mid-way by ertn, the next one must still finish
        allow_mode = 2;
        @(posedge clk);
        #1;
        offer_item(div_a_idx, 1'b0);
        repeat (5) @(posedge clk);
        #1;
        wb_ertn = 1'b1;
        @(posedge clk);
        #1;
        wb_ertn = 1'b0;
        offer_item(div_b_idx, 1'b1);
        offer_item(0, 1'b1);
        wait_drain();

        $display("checks %0d, value errors %0d, other errors %0d",
                 num_checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* exe_subsys.f */
+incdir+include
source/exe_pkg.sv
source/div_unit.sv
source/alu.sv
source/exe_stage.sv
source/exe_top.sv
test/exe_tb.sv

/* Bender.yml */
package:
  name: exe_subsys

sources:
  - files:
      - source/exe_pkg.sv
      - source/div_unit.sv
      - source/alu.sv
      - source/exe_stage.sv
      - source/exe_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/exe_tb.sv
